/* bench/tb_wh_test_mem.sv */
// wormhole test memory testbench
`timescale 1ns/10ps
`include "wh_test_mem_cfg.svh"

module tb_wh_test_mem;

  localparam int FLIT_W = `WH_FLIT_WIDTH;
  localparam int BURST  = `DMA_BURST_LEN;
  localparam logic [7:0] MEM_CORD = 8'h10;
  // about 40 packets of up to 6 flits, replies at 50% back-pressure, ~250 cycles
  localparam int MAX_CYCLES = 2000;

  logic               clk_i;
  logic               rst_i;
  logic [FLIT_W-1:0]  in_flit_i;
  logic               in_v_i;
  logic               in_ready_o;
  logic [FLIT_W-1:0]  out_flit_o;
  logic               out_v_o;
  logic               out_ready_i = 1'b1;

  logic [FLIT_W-1:0]  ref_mem [`NUM_CACHES][`MEM_WORDS_PER_CACHE];
  logic [FLIT_W-1:0]  exp_q [$];
  integer             seed = 32'h854bd41c;
  logic               backpressure;
  int                 err_count;
  int                 test_count;
  int                 test_fail_count;
  int                 cycle_count;

  wh_test_mem u_dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_flit_i   (in_flit_i),
    .in_v_i      (in_v_i),
    .in_ready_o  (in_ready_o),
    .out_flit_o  (out_flit_o),
    .out_v_o     (out_v_o),
    .out_ready_i (out_ready_i)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [FLIT_W-1:0] make_header(input logic [7:0] dest,
      input logic [3:0] len, input logic [7:0] src, input logic [1:0] cid, input logic op);
    logic [FLIT_W-1:0] flit;
    flit = '0;
    flit[7:0]   = dest;
    flit[11:8]  = len;
    flit[19:12] = src;
    flit[21:20] = cid;
    flit[22]    = op;
    return flit;
  endfunction

  // cache id sits in source cord bits 2:1
  function automatic logic [1:0] cache_of(input logic [7:0] src);
    return src[2:1];
  endfunction

  function automatic logic [5:0] word_index(input logic [31:0] byte_addr, input int beat);
    int w;
    w = int'(byte_addr / 4) % `MEM_WORDS_PER_CACHE;
    w = w - (w % BURST) + beat;
    return 6'(w);
  endfunction

  // idx 0 is the reply header, 1 to 4 the block words
  function automatic logic [FLIT_W-1:0] expected_response(input logic [7:0] src,
      input logic [1:0] cid, input logic [31:0] byte_addr, input int idx);
    if (idx == 0) begin
      return make_header(src, 4'(BURST), 8'h00, cid, 1'b0);
    end
    return ref_mem[cache_of(src)][word_index(byte_addr, idx - 1)];
  endfunction

  task automatic send_flit(input logic [FLIT_W-1:0] flit);
    logic taken;
    in_flit_i = flit;
    in_v_i    = 1'b1;
    taken     = 1'b0;
    while (!taken) begin
      taken = in_ready_o;
      @(posedge clk_i);
      #1;
    end
    in_v_i = 1'b0;
  endtask

  task automatic write_block(input logic [7:0] src, input logic [1:0] cid,
      input logic [31:0] addr, input logic [BURST*FLIT_W-1:0] data);
    send_flit(make_header(MEM_CORD, 4'(BURST + 1), src, cid, 1'b1));
    send_flit(addr);
    for (int i = 0; i < BURST; i++) begin
      ref_mem[cache_of(src)][word_index(addr, i)] = data[i*FLIT_W +: FLIT_W];
      send_flit(data[i*FLIT_W +: FLIT_W]);
    end
  endtask

  task automatic read_block(input logic [7:0] src, input logic [1:0] cid,
      input logic [31:0] addr);
    for (int i = 0; i <= BURST; i++) begin
      exp_q.push_back(expected_response(src, cid, addr, i));
    end
    send_flit(make_header(MEM_CORD, 4'd1, src, cid, 1'b0));
    send_flit(addr);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    #1;
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      test_fail_count++;
      $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
    end
  endtask

  always @(posedge clk_i) begin : drive_ready
    logic [31:0] rnd;
    #1;
    rnd = $random(seed);
    out_ready_i = backpressure ? rnd[0] : 1'b1;
  end

  // compare every transferred flit against the queue
  always @(negedge clk_i) begin : check_output
    logic [FLIT_W-1:0] exp;
    if (!rst_i && out_v_o && out_ready_i) begin
      assert (exp_q.size() != 0) else begin
        $display("output flit %h at %0t arrived with no reply outstanding", out_flit_o, $time);
        err_count++;
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        assert (out_flit_o === exp) else begin
          $display("ERR %0t out_flit_o got %h expected %h", $time, out_flit_o, exp);
          err_count++;
        end
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin : run_tests
    int errs;
    logic [BURST*FLIT_W-1:0] blk;
    logic [31:0] rnd;
    clk_i        = 1'b0;
    rst_i        = 1'b1;
    in_flit_i    = '0;
    in_v_i       = 1'b0;
    backpressure = 1'b0;
    foreach (ref_mem[c, w]) begin
      ref_mem[c][w] = '0;
    end
    errs = err_count;
    @(posedge clk_i);
    @(negedge clk_i);
    assert (in_ready_o === 1'b0) else begin
      $display("ERR %0t in_ready_o got %b expected 0", $time, in_ready_o);
      err_count++;
    end
    assert (out_v_o === 1'b0) else begin
      $display("ERR %0t out_v_o got %b expected 0", $time, out_v_o);
      err_count++;
    end
    @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    repeat (6) begin
      @(negedge clk_i);
      assert (out_v_o === 1'b0) else begin
        $display("ERR %0t out_v_o got %b expected 0", $time, out_v_o);
        err_count++;
      end
    end
    @(posedge clk_i);
    #1;
    read_block(8'h06, 2'd0, 32'h0000_00f0);
    wait_drain();
    report_test(6, "quiet after reset", errs);

    errs = err_count;
    write_block(8'h01, 2'd1, 32'h0000_0020, {32'hd4, 32'hc3, 32'hb2, 32'ha1});
    read_block(8'h01, 2'd1, 32'h0000_0020);
    wait_drain();
    report_test(1, "write then read back", errs);

    errs = err_count;
    write_block(8'ha5, 2'd3, 32'h0000_0010, {32'h4444, 32'h3333, 32'h2222, 32'h1111});
    read_block(8'ha5, 2'd2, 32'h0000_0010);
    wait_drain();
    report_test(2, "response header", errs);

    errs = err_count;
    for (int c = 0; c < `NUM_CACHES; c++) begin
      blk = {4{32'hc0de_0000 + 32'(c)}} + {32'h3, 32'h2, 32'h1, 32'h0};
      write_block({5'b00110, 2'(c), 1'b1}, 2'd0, 32'h0000_0080, blk);
    end
    for (int c = 0; c < `NUM_CACHES; c++) begin
      read_block({5'b00110, 2'(c), 1'b1}, 2'(c), 32'h0000_0080);
    end
    wait_drain();
    report_test(3, "per-cache regions", errs);

    errs = err_count;
    write_block(8'h02, 2'd1, 32'h0000_0040, {32'h0bad_0004, 32'h0bad_0003, 32'h0bad_0002,
      32'h0bad_0001});
    read_block(8'h02, 2'd1, 32'h0000_0140);
    read_block(8'h02, 2'd1, 32'h0000_004c);
    read_block(8'h02, 2'd1, 32'h0000_0247);
    wait_drain();
    report_test(4, "address wrap", errs);

    errs = err_count;
    backpressure = 1'b1;
    for (int n = 0; n < 20; n++) begin
      rnd = $random(seed);
      if (rnd[0]) begin
        blk = {$random(seed), $random(seed), $random(seed), $random(seed)};
        write_block(rnd[15:8], rnd[17:16], $random(seed), blk);
      end else begin
        read_block(rnd[15:8], rnd[17:16], $random(seed));
      end
    end
    wait_drain();
    backpressure = 1'b0;
    report_test(5, "back-pressure and ordering", errs);

    $display("tests run %0d, tests failed %0d, errors %0d", test_count, test_fail_count,
      err_count);
    if (err_count == 0 && test_fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* logic/dma_fifo.sv */
// valid/yumi buffer FIFO
`timescale 1ns/10ps
`include "wh_test_mem_cfg.svh"

module dma_fifo #(
  parameter int width_p = `WH_FLIT_WIDTH,
  parameter int els_p   = `FIFO_DEPTH
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic [width_p-1:0]  data_i,
  input  logic                v_i,
  output logic                ready_o,
  output logic [width_p-1:0]  data_o,
  output logic                v_o,
  input  logic                yumi_i
);

  localparam int PTR_W = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int CNT_W = $clog2(els_p + 1);

  logic [width_p-1:0] mem_r [els_p];
  logic [PTR_W-1:0]   rd_ptr_r;
  logic [PTR_W-1:0]   wr_ptr_r;
  logic [CNT_W-1:0]   count_r;
  logic               push;
  logic               pop;

  // pointers wrap at els_p, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(els_p - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign ready_o = (count_r != CNT_W'(els_p));
  assign v_o     = (count_r != '0);
  assign push    = v_i & ready_o;
  assign pop     = yumi_i & v_o;
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (pop) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // producer only offers an item when there is room
  assert property (@(posedge clk_i) disable iff (rst_i) v_i |-> ready_o)
    else $error("push into a full FIFO");

  assert property (@(posedge clk_i) disable iff (rst_i) yumi_i |-> v_o)
    else $error("yumi on an empty FIFO");

endmodule

/* logic/test_mem_responder.sv */
// test memory responder
`timescale 1ns/10ps
`include "wh_test_mem_cfg.svh"

module test_mem_responder (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  wh_test_mem_pkg::dma_req_s    req_i,
  input  logic                         req_v_i,
  output logic                         req_yumi_o,
  input  logic [`WH_FLIT_WIDTH-1:0]    wdata_i,
  input  logic                         wdata_v_i,
  output logic                         wdata_yumi_o,
  output logic [`WH_FLIT_WIDTH-1:0]    out_flit_o,
  output logic                         out_v_o,
  input  logic                         out_ready_i
);
  import wh_test_mem_pkg::*;

  localparam int FLIT_W = `WH_FLIT_WIDTH;
  localparam int CORD_W = `WH_CORD_WIDTH;
  localparam int LEN_W  = `WH_LEN_WIDTH;
  localparam int WORD_W = `MEM_WORD_ADDR_WIDTH;
  localparam int BEAT_W = `DMA_BEAT_WIDTH;
  // unused upper bits of the header flit
  localparam int PAD_W  = FLIT_W - (2 * CORD_W + LEN_W + `WH_CID_WIDTH + 1);

  resp_state_e        state_r;
  dma_req_s           req_r;
  logic [BEAT_W-1:0]  beat_r;
  logic               last_beat;
  logic [WORD_W-1:0]  word_idx;
  logic [FLIT_W-1:0]  resp_header;
  logic [FLIT_W-1:0]  mem_r [`NUM_CACHES][`MEM_WORDS_PER_CACHE];

  // block base plus beat
  assign word_idx  = {req_r.word_addr[WORD_W-1:BEAT_W], beat_r};
  assign last_beat = (beat_r == BEAT_W'(`DMA_BURST_LEN - 1));

  assign req_yumi_o   = (state_r == RESP_IDLE) & req_v_i;
  assign wdata_yumi_o = (state_r == RESP_WRITE) & wdata_v_i;

  // reply goes back to the requester, source cord 0
  assign resp_header = {
    {PAD_W{1'b0}},
    req_r.opcode,
    req_r.cid,
    {CORD_W{1'b0}},
    LEN_W'(`DMA_BURST_LEN),
    req_r.return_cord
  };

  assign out_v_o    = (state_r == RESP_HEADER) | (state_r == RESP_DATA);
  assign out_flit_o = (state_r == RESP_HEADER) ? resp_header
                                               : mem_r[req_r.cache_id][word_idx];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= RESP_IDLE;
      beat_r  <= '0;
    end else begin
      case (state_r)
        RESP_IDLE: begin
          if (req_v_i) begin
            beat_r <= '0;
            if (req_i.opcode == WH_WRITE) begin
              state_r <= RESP_WRITE;
            end else begin
              state_r <= RESP_HEADER;
            end
          end
        end
        RESP_WRITE: begin
          // one data word per cycle while the FIFO has one
          if (wdata_v_i) begin
            beat_r <= beat_r + 1'b1;
            if (last_beat) begin
              state_r <= RESP_IDLE;
            end
          end
        end
        RESP_HEADER: begin
          if (out_ready_i) begin
            state_r <= RESP_DATA;
          end
        end
        default: begin
          if (out_ready_i) begin
            beat_r <= beat_r + 1'b1;
            if (last_beat) begin
              state_r <= RESP_IDLE;
            end
          end
        end
      endcase
    end
  end

  // request held until its packet is done
  always_ff @(posedge clk_i) begin
    if (req_yumi_o) begin
      req_r <= req_i;
    end
  end

  // memory starts out zeroed
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int c = 0; c < `NUM_CACHES; c++) begin
        for (int w = 0; w < `MEM_WORDS_PER_CACHE; w++) begin
          mem_r[c][w] <= '0;
        end
      end
    end else if (wdata_yumi_o) begin
      mem_r[req_r.cache_id][word_idx] <= wdata_i;
    end
  end

  // an offered flit is held until the link takes it
  assert property (@(posedge clk_i) disable iff (rst_i)
    (out_v_o && !out_ready_i) |=> (out_v_o && $stable(out_flit_o)))
    else $error("output flit changed under back-pressure");

endmodule

/* logic/wh_packet_unpacker.sv */
// wormhole packet unpacker
`timescale 1ns/10ps
`include "wh_test_mem_cfg.svh"

module wh_packet_unpacker (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [`WH_FLIT_WIDTH-1:0]    in_flit_i,
  input  logic                         in_v_i,
  output logic                         in_ready_o,
  output wh_test_mem_pkg::dma_req_s    req_o,
  output logic                         req_v_o,
  input  logic                         req_ready_i,
  output logic [`WH_FLIT_WIDTH-1:0]    wdata_o,
  output logic                         wdata_v_o,
  input  logic                         wdata_ready_i
);
  import wh_test_mem_pkg::*;

  localparam int CORD_W  = `WH_CORD_WIDTH;
  localparam int LEN_W   = `WH_LEN_WIDTH;
  localparam int CID_W   = `WH_CID_WIDTH;
  localparam int WORD_W  = `MEM_WORD_ADDR_WIDTH;
  localparam int BEAT_W  = `DMA_BEAT_WIDTH;
  localparam int LEN_LSB = CORD_W;
  localparam int SRC_LSB = LEN_LSB + LEN_W;
  localparam int CID_LSB = SRC_LSB + CORD_W;
  localparam int OP_LSB  = CID_LSB + CID_W;
  // byte offset inside one word
  localparam int BYTE_W  = $clog2(`WH_FLIT_WIDTH / 8);

  unpack_state_e       state_r;
  logic                live_r;
  logic                in_fire;
  logic [LEN_W-1:0]    data_cnt_r;
  logic [CORD_W-1:0]   src_cord_r;
  logic [CID_W-1:0]    cid_r;
  logic [LEN_W-1:0]    len_r;
  wh_opcode_e          opcode_r;

  // link opens one cycle after reset is released
  always_comb begin
    case (state_r)
      UNPACK_HEADER: in_ready_o = live_r;
      UNPACK_ADDR:   in_ready_o = req_ready_i;
      default:       in_ready_o = wdata_ready_i;
    endcase
  end

  assign in_fire = in_v_i & in_ready_o;

  // request is pushed while the address flit transfers
  assign req_v_o = in_fire & (state_r == UNPACK_ADDR);

  always_comb begin
    req_o.opcode      = opcode_r;
    req_o.cache_id    = src_cord_r[`WH_RUCHE_BITS +: `CACHE_ID_WIDTH];
    // byte address to block-aligned word index, wraps per region
    req_o.word_addr   = {in_flit_i[BYTE_W+BEAT_W +: WORD_W-BEAT_W], {BEAT_W{1'b0}}};
    req_o.return_cord = src_cord_r;
    req_o.cid         = cid_r;
  end

  // write data goes straight into the data FIFO
  assign wdata_o   = in_flit_i;
  assign wdata_v_o = in_fire & (state_r == UNPACK_DATA);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r    <= UNPACK_HEADER;
      live_r     <= 1'b0;
      data_cnt_r <= '0;
    end else begin
      live_r <= 1'b1;
      if (in_fire) begin
        case (state_r)
          UNPACK_HEADER: begin
            state_r <= UNPACK_ADDR;
          end
          UNPACK_ADDR: begin
            // flits left after the address
            data_cnt_r <= len_r - 1'b1;
            if (opcode_r == WH_WRITE) begin
              state_r <= UNPACK_DATA;
            end else begin
              state_r <= UNPACK_HEADER;
            end
          end
          default: begin
            data_cnt_r <= data_cnt_r - 1'b1;
            if (data_cnt_r == LEN_W'(1)) begin
              state_r <= UNPACK_HEADER;
            end
          end
        endcase
      end
    end
  end

  // header fields held for the rest of the packet
  always_ff @(posedge clk_i) begin
    if (in_fire && (state_r == UNPACK_HEADER)) begin
      len_r      <= in_flit_i[LEN_LSB +: LEN_W];
      src_cord_r <= in_flit_i[SRC_LSB +: CORD_W];
      cid_r      <= in_flit_i[CID_LSB +: CID_W];
      opcode_r   <= wh_opcode_e'(in_flit_i[OP_LSB]);
    end
  end

  // a write carries one address and a full block, a read only the address
  assert property (@(posedge clk_i) disable iff (rst_i)
    (in_fire && (state_r == UNPACK_HEADER)) |->
      (in_flit_i[LEN_LSB +: LEN_W] ==
        (in_flit_i[OP_LSB] ? LEN_W'(`DMA_BURST_LEN + 1) : LEN_W'(1))))
    else $error("header len does not match opcode");

endmodule

/* logic/wh_test_mem.sv */
// wormhole test memory top
`timescale 1ns/10ps
`include "wh_test_mem_cfg.svh"

module wh_test_mem (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [`WH_FLIT_WIDTH-1:0]    in_flit_i,
  input  logic                         in_v_i,
  output logic                         in_ready_o,
  output logic [`WH_FLIT_WIDTH-1:0]    out_flit_o,
  output logic                         out_v_o,
  input  logic                         out_ready_i
);
  import wh_test_mem_pkg::*;

  localparam int REQ_W = $bits(dma_req_s);

  // unpacker to request FIFO
  dma_req_s                   req_lo;
  logic                       req_v_lo;
  logic                       req_ready_li;

  // unpacker to write-data FIFO
  logic [`WH_FLIT_WIDTH-1:0]  wdata_lo;
  logic                       wdata_v_lo;
  logic                       wdata_ready_li;

  // FIFOs to responder
  dma_req_s                   fifo_req_lo;
  logic                       fifo_req_v_lo;
  logic                       fifo_req_yumi_li;
  logic [`WH_FLIT_WIDTH-1:0]  fifo_wdata_lo;
  logic                       fifo_wdata_v_lo;
  logic                       fifo_wdata_yumi_li;

  wh_packet_unpacker u_unpacker (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .in_flit_i     (in_flit_i),
    .in_v_i        (in_v_i),
    .in_ready_o    (in_ready_o),
    .req_o         (req_lo),
    .req_v_o       (req_v_lo),
    .req_ready_i   (req_ready_li),
    .wdata_o       (wdata_lo),
    .wdata_v_o     (wdata_v_lo),
    .wdata_ready_i (wdata_ready_li)
  );

  dma_fifo #(
    .width_p (REQ_W),
    .els_p   (`FIFO_DEPTH)
  ) u_req_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (req_lo),
    .v_i     (req_v_lo),
    .ready_o (req_ready_li),
    .data_o  (fifo_req_lo),
    .v_o     (fifo_req_v_lo),
    .yumi_i  (fifo_req_yumi_li)
  );

  dma_fifo #(
    .width_p (`WH_FLIT_WIDTH),
    .els_p   (`FIFO_DEPTH)
  ) u_wdata_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (wdata_lo),
    .v_i     (wdata_v_lo),
    .ready_o (wdata_ready_li),
    .data_o  (fifo_wdata_lo),
    .v_o     (fifo_wdata_v_lo),
    .yumi_i  (fifo_wdata_yumi_li)
  );

  test_mem_responder u_responder (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (fifo_req_lo),
    .req_v_i      (fifo_req_v_lo),
    .req_yumi_o   (fifo_req_yumi_li),
    .wdata_i      (fifo_wdata_lo),
    .wdata_v_i    (fifo_wdata_v_lo),
    .wdata_yumi_o (fifo_wdata_yumi_li),
    .out_flit_o   (out_flit_o),
    .out_v_o      (out_v_o),
    .out_ready_i  (out_ready_i)
  );

endmodule

/* logic/wh_test_mem_cfg.svh */
// wormhole test memory configuration
`ifndef WH_TEST_MEM_CFG_SVH
`define WH_TEST_MEM_CFG_SVH

// wormhole link fields
`define WH_FLIT_WIDTH 32
`define WH_CORD_WIDTH 8
`define WH_LEN_WIDTH 4
`define WH_CID_WIDTH 2

// dma block shape
`define DMA_BURST_LEN 4
`define DMA_BEAT_WIDTH 2

// caches behind the link
`define NUM_CACHES 4
`define CACHE_ID_WIDTH 2
// source cord bits skipped before the cache id
`define WH_RUCHE_BITS 1

// per-cache memory region
`define MEM_WORDS_PER_CACHE 64
`define MEM_WORD_ADDR_WIDTH 6

`define FIFO_DEPTH 4

`endif

/* logic/wh_test_mem_pkg.sv */
// wormhole test memory types
`include "wh_test_mem_cfg.svh"

package wh_test_mem_pkg;

  // opcode bit of the header flit
  typedef enum logic {
    WH_READ  = 1'b0,
    WH_WRITE = 1'b1
  } wh_opcode_e;

  typedef enum logic [1:0] {
    UNPACK_HEADER = 2'd0,
    UNPACK_ADDR   = 2'd1,
    UNPACK_DATA   = 2'd2
  } unpack_state_e;

  typedef enum logic [1:0] {
    RESP_IDLE   = 2'd0,
    RESP_WRITE  = 2'd1,
    RESP_HEADER = 2'd2,
    RESP_DATA   = 2'd3
  } resp_state_e;

  // one block request as seen by the memory
  typedef struct packed {
    wh_opcode_e                       opcode;
    logic [`CACHE_ID_WIDTH-1:0]       cache_id;
    // word index of the block, low beat bits are zero
    logic [`MEM_WORD_ADDR_WIDTH-1:0]  word_addr;
    logic [`WH_CORD_WIDTH-1:0]        return_cord;
    logic [`WH_CID_WIDTH-1:0]         cid;
  } dma_req_s;

endpackage

/* run_sim.sh */
#!/bin/sh
# build and run the wormhole test memory testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_wh_test_mem -f sources.f -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb | tee sim.log \
  || echo "build or simulation run failed"
grep -q "PASS: all tests" sim.log \
  && echo "simulation passed" \
  && exit 0 \
  || { echo "simulation did not pass"; exit 1; }

/* sources.f */
+incdir+logic
logic/wh_test_mem_pkg.sv
logic/dma_fifo.sv
logic/wh_packet_unpacker.sv
logic/test_mem_responder.sv
logic/wh_test_mem.sv
bench/tb_wh_test_mem.sv
